// ==== cnode_pkg.sv ====
package cnode_pkg;

  // ----------------------------------------
  // llr format
  // ----------------------------------------

  localparam int cLLR_W   = 5;                  // two's complement, sign + 4 bit mag
  localparam int cDEG_MAX = 32;                 // largest check row degree

  localparam int cMAG_W   = cLLR_W - 1;
  localparam int cIDX_W   = $clog2(cDEG_MAX);   // 5 bits for 32 positions

  // ----------------------------------------
  // derived types
  // ----------------------------------------

  typedef logic signed [cLLR_W-1 : 0] llr_t;
  typedef logic        [cMAG_W-1 : 0] mag_t;
  typedef logic        [cIDX_W-1 : 0] deg_idx_t; // position inside a row

  // ----------------------------------------
  // min-sum normalization
  // ----------------------------------------

  // scale by 3/4 as mag - mag/4, floor of the quarter
  function automatic mag_t norm_mag(input mag_t mag, input bit use_norm);
    mag_t quarter;
    quarter = mag >> 2;
    if (use_norm) begin
      return mag_t'(mag - quarter);
    end
    return mag;                                   // plain min-sum
  endfunction

endpackage

// ==== lane_in_if.sv ====
`timescale 1ns/1ps

// dispatcher -> search lanes, one beat per vnode position
interface lane_in_if #(
  parameter int pLANES = 4
);

  import cnode_pkg::*;

  logic              sop;           // first position of a row
  logic              val;           // beat valid
  logic              eop;           // last position of a row
  deg_idx_t          idx;           // position, 0 on sop
  logic [pLANES-1:0] sign;          // one sign per lane
  mag_t              mag [pLANES];  // saturated magnitude per lane

  // single driver, the dispatcher
  modport dispatch (
    output sop, val, eop, idx, sign, mag
  );

  // every lane reads all, picks its own element
  modport lane (
    input  sop, val, eop, idx, sign, mag
  );

endinterface

// ==== lane_out_if.sv ====
`timescale 1ns/1ps

// search lanes -> collector, check-node messages in sign/mag form
interface lane_out_if #(
  parameter int pLANES = 4
);

  import cnode_pkg::*;

  logic              sop;                 // lane 0 only, lanes run in lockstep
  logic              val;
  logic              eop;
  logic              busy;                // lane 0 output bank in use
  logic [pLANES-1:0] sign;                // element g from lane g
  mag_t              mag [pLANES];
  logic [pLANES-1:0] parity_fail;         // valid with eop

  modport lane (
    output sop, val, eop, busy, sign, mag, parity_fail
  );

  modport collect (
    input  sop, val, eop, busy, sign, mag, parity_fail
  );

endinterface

// ==== vnode_dispatch.sv ====
`timescale 1ns/1ps

module vnode_dispatch #(
  parameter int pLANES = 4
) (
  input  logic            iclk,
  input  logic            ireset,
  input  logic            ival,
  input  logic            isop,
  input  logic            ieop,
  input  cnode_pkg::llr_t ivnode [pLANES],
  lane_in_if.dispatch     li
);

  import cnode_pkg::*;

  localparam llr_t cLLR_MIN = {1'b1, {(cLLR_W-1){1'b0}}};  // -16, no positive twin

  logic [pLANES-1:0] in_sign;
  mag_t              in_mag [pLANES];
  deg_idx_t          idx_cnt;             // position of the next beat

  // ----------------------------------------
  // two's complement -> sign/magnitude
  // ----------------------------------------

  always_comb begin
    for (int l = 0; l < pLANES; l++) begin
      in_sign[l] = ivnode[l][cLLR_W-1];
      if (ivnode[l] == cLLR_MIN) begin
        in_mag[l] = '1;                                      // saturate to 15
      end
      else if (in_sign[l]) begin
        in_mag[l] = mag_t'(-ivnode[l]);
      end
      else begin
        in_mag[l] = ivnode[l][cLLR_W-2 : 0];
      end
    end
  end

  // ----------------------------------------
  // input register, frame flags and position count
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      li.sop  <= 1'b0;
      li.val  <= 1'b0;
      li.eop  <= 1'b0;
      idx_cnt <= '0;
    end
    else begin
      li.val <= ival;
      li.sop <= ival & isop;                  // flags only count on valid beats
      li.eop <= ival & ieop;
      if (ival) begin
        idx_cnt <= isop ? deg_idx_t'(1) : deg_idx_t'(idx_cnt + 1'b1);
      end
    end
  end

  // payload, follows val
  always_ff @(posedge iclk) begin
    li.idx <= isop ? '0 : idx_cnt;
    for (int l = 0; l < pLANES; l++) begin
      li.sign[l] <= in_sign[l];
      li.mag[l]  <= in_mag[l];
    end
  end

endmodule

// ==== min_search_lane.sv ====
`timescale 1ns/1ps

module min_search_lane #(
  parameter bit pUSE_NORM = 1,
  parameter int pLANE_IDX = 0   // which element of the lane arrays is ours
) (
  input  logic    iclk,
  input  logic    ireset,
  lane_in_if.lane li,
  lane_out_if.lane lo
);

  import cnode_pkg::*;

  // running search state
  mag_t                  min1;
  mag_t                  min2;
  deg_idx_t              min1_idx;
  logic                  sxor;
  logic [cDEG_MAX-1 : 0] signs;        // shift store, newest sign in bit 0

  // next search state, also what the bank takes on eop
  logic                  cur_sign;
  mag_t                  cur_mag;
  mag_t                  nxt_min1;
  mag_t                  nxt_min2;
  deg_idx_t              nxt_idx;
  logic                  nxt_sxor;
  logic [cDEG_MAX-1 : 0] nxt_signs;

  // output bank, holds one finished row
  mag_t                  b_min1;
  mag_t                  b_min2;
  deg_idx_t              b_idx;
  logic                  b_sxor;
  logic [cDEG_MAX-1 : 0] b_signs;
  deg_idx_t              b_last;       // degree - 1

  logic                  bank_act;     // output walk in progress
  deg_idx_t              out_cnt;
  logic                  out_sign;
  mag_t                  out_mag;
  logic                  out_pfail;

  // ----------------------------------------
  // min1/min2 search
  // ----------------------------------------

  always_comb begin
    cur_sign  = li.sign[pLANE_IDX];
    cur_mag   = li.mag[pLANE_IDX];
    nxt_signs = {signs[cDEG_MAX-2 : 0], cur_sign};
    if (li.sop) begin                   // restart on first position
      nxt_min1 = cur_mag;
      nxt_min2 = '1;
      nxt_idx  = li.idx;
      nxt_sxor = cur_sign;
    end
    else begin
      nxt_min1 = min1;
      nxt_min2 = min2;
      nxt_idx  = min1_idx;
      nxt_sxor = sxor ^ cur_sign;
      if (cur_mag < min1) begin         // new minimum, old one drops to min2
        nxt_min1 = cur_mag;
        nxt_min2 = min1;
        nxt_idx  = li.idx;
      end
      else if (cur_mag < min2) begin
        nxt_min2 = cur_mag;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (li.val) begin
      min1     <= nxt_min1;
      min2     <= nxt_min2;
      min1_idx <= nxt_idx;
      sxor     <= nxt_sxor;
      signs    <= nxt_signs;
    end
    // bank load on the eop beat, search is free next cycle
    if (li.val & li.eop) begin
      b_min1  <= nxt_min1;
      b_min2  <= nxt_min2;
      b_idx   <= nxt_idx;
      b_sxor  <= nxt_sxor;
      b_signs <= nxt_signs;
      b_last  <= li.idx;
    end
  end

  // ----------------------------------------
  // output walk over the bank
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      bank_act <= 1'b0;
      out_cnt  <= '0;
    end
    else if (li.val & li.eop) begin
      bank_act <= 1'b1;
      out_cnt  <= '0;
    end
    else if (bank_act) begin
      out_cnt <= deg_idx_t'(out_cnt + 1'b1);
      if (out_cnt == b_last) begin
        bank_act <= 1'b0;                // last message issued
      end
    end
  end

  // message: min2 at the min1 position, min1 elsewhere; sign excludes own
  always_ff @(posedge iclk) begin
    out_mag   <= norm_mag((out_cnt == b_idx) ? b_min2 : b_min1, pUSE_NORM);
    out_sign  <= b_sxor ^ b_signs[deg_idx_t'(b_last - out_cnt)];
    out_pfail <= b_sxor;                 // odd count of negatives
  end

  assign lo.sign[pLANE_IDX]        = out_sign;
  assign lo.mag[pLANE_IDX]         = out_mag;
  assign lo.parity_fail[pLANE_IDX] = out_pfail;

  // frame flags come from lane 0
  if (pLANE_IDX == 0) begin : g_ctl
    logic out_sop;
    logic out_val;
    logic out_eop;

    always_ff @(posedge iclk or posedge ireset) begin
      if (ireset) begin
        out_sop <= 1'b0;
        out_val <= 1'b0;
        out_eop <= 1'b0;
      end
      else begin
        out_val <= bank_act;
        out_sop <= bank_act & (out_cnt == '0);
        out_eop <= bank_act & (out_cnt == b_last);
      end
    end

    assign lo.sop  = out_sop;
    assign lo.val  = out_val;
    assign lo.eop  = out_eop;
    assign lo.busy = bank_act;
  end

endmodule

// ==== cnode_collect.sv ====
`timescale 1ns/1ps

module cnode_collect #(
  parameter int pLANES = 4
) (
  input  logic            iclk,
  input  logic            ireset,
  lane_out_if.collect     lo,
  output logic            oval,
  output logic            osop,
  output logic            oeop,
  output cnode_pkg::llr_t ocnode [pLANES],
  output logic            odecfail,
  output logic            obusy
);

  import cnode_pkg::*;

  // sign/magnitude back to two's complement, no negative zero
  function automatic llr_t to_llr(input logic sign, input mag_t mag);
    llr_t pos;
    pos = llr_t'({1'b0, mag});
    if (sign && (mag != '0)) begin
      return -pos;
    end
    return pos;
  endfunction

  // ----------------------------------------
  // frame flags and decode fail
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval     <= 1'b0;
      osop     <= 1'b0;
      oeop     <= 1'b0;
      odecfail <= 1'b0;
    end
    else begin
      oval     <= lo.val;
      osop     <= lo.val & lo.sop;
      oeop     <= lo.val & lo.eop;
      odecfail <= lo.val & lo.eop & (|lo.parity_fail);   // any row with odd negatives
    end
  end

  // ----------------------------------------
  // message data
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    for (int l = 0; l < pLANES; l++) begin
      ocnode[l] <= to_llr(lo.sign[l], lo.mag[l]);
    end
  end

  // bank in use -> messages in flight -> last output beat
  assign obusy = lo.busy | lo.val | oval;

endmodule

// ==== cnode_unit.sv ====
`timescale 1ns/1ps

module cnode_unit #(
  parameter int pLANES    = 4,
  parameter bit pUSE_NORM = 1
) (
  input  logic            iclk,
  input  logic            ireset,
  input  logic            ival,
  input  logic            isop,
  input  logic            ieop,
  input  cnode_pkg::llr_t ivnode [pLANES],
  output logic            oval,
  output logic            osop,
  output logic            oeop,
  output cnode_pkg::llr_t ocnode [pLANES],
  output logic            odecfail,
  output logic            obusy
);

  lane_in_if  #(.pLANES(pLANES)) lane_in  ();
  lane_out_if #(.pLANES(pLANES)) lane_out ();

  // ----------------------------------------
  // input register and llr split
  // ----------------------------------------

  vnode_dispatch #(
    .pLANES (pLANES)
  ) vnode_dispatch_i (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (ival),
    .isop   (isop),
    .ieop   (ieop),
    .ivnode (ivnode),
    .li     (lane_in.dispatch)
  );

  // ----------------------------------------
  // one search engine per check row
  // ----------------------------------------

  for (genvar g = 0; g < pLANES; g++) begin : g_lane
    min_search_lane #(
      .pUSE_NORM (pUSE_NORM),
      .pLANE_IDX (g)
    ) min_search_lane_i (
      .iclk   (iclk),
      .ireset (ireset),
      .li     (lane_in.lane),
      .lo     (lane_out.lane)
    );
  end

  // output format, decode fail and busy
  cnode_collect #(
    .pLANES (pLANES)
  ) cnode_collect_i (
    .iclk     (iclk),
    .ireset   (ireset),
    .lo       (lane_out.collect),
    .oval     (oval),
    .osop     (osop),
    .oeop     (oeop),
    .ocnode   (ocnode),
    .odecfail (odecfail),
    .obusy    (obusy)
  );

endmodule

// ==== tb_cnode_checks.svh ====
// error counters, bumped by the compare tasks
int mismatch_cnt = 0;
int other_cnt    = 0;

// ----------------------------------------
// reference model for one check row
// ----------------------------------------

// min-sum message per position, sign excludes the position's own sign
function automatic void ref_cnode(
  input  llr_t row [cDEG_MAX],
  input  int   deg,
  input  bit   use_norm,
  output llr_t msg [cDEG_MAX],
  output logic pfail
);
  int   mags [cDEG_MAX];
  int   m1;
  int   m2;
  int   m1_pos;
  int   m;
  logic sx;
  m1     = 15;
  m2     = 15;              // degree 1 leaves min2 at full scale
  m1_pos = 0;
  sx     = 1'b0;
  for (int p = 0; p < deg; p++) begin
    if (row[p] == -16) mags[p] = 15;   // saturate, no +16
    else if (row[p] < 0) mags[p] = -row[p];
    else mags[p] = row[p];
    sx = sx ^ row[p][cLLR_W-1];
  end
  // first smallest wins on ties
  for (int p = deg - 1; p >= 0; p--) begin
    if (mags[p] <= m1) begin
      m1     = mags[p];
      m1_pos = p;
    end
  end
  for (int p = 0; p < deg; p++) begin
    if (p != m1_pos && mags[p] < m2) m2 = mags[p];
  end
  for (int p = 0; p < cDEG_MAX; p++) begin
    msg[p] = '0;
  end
  for (int p = 0; p < deg; p++) begin
    m = (p == m1_pos) ? m2 : m1;
    if (use_norm) m = m - (m / 4);     // 3/4 scaling, floor of the quarter
    if (m != 0 && (sx ^ row[p][cLLR_W-1])) msg[p] = llr_t'(-m);
    else msg[p] = llr_t'(m);
  end
  pfail = sx;
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------

task automatic check_llr(input string name, input llr_t exp, input llr_t act);
  if (act !== exp) begin
    mismatch_cnt++;
    $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    mismatch_cnt++;
    $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
  end
endtask

// cycle numbers for the latency check
task automatic check_count(input string name, input int exp, input int act);
  if (act != exp) begin
    mismatch_cnt++;
    $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
  end
endtask

task automatic report_error(input string what);
  other_cnt++;
  $display("Error at %0t: %s", $time, what);
endtask

// ==== tb_cnode_unit.sv ====
`timescale 1ns/1ps

module tb_cnode_unit;

  import cnode_pkg::*;

  localparam int PLANES = 4;
  localparam int NDIR   = 5;                 // directed frames
  localparam int NFR    = NDIR + 20;         // plus random frames

  logic iclk;
  logic ireset;
  logic ival;
  logic isop;
  logic ieop;
  llr_t ivnode [PLANES];
  logic oval;
  logic osop;
  logic oeop;
  llr_t ocnode [PLANES];
  logic odecfail;
  logic obusy;

  `include "tb_cnode_checks.svh"

  int   seed = 96047;
  int   edge_cnt = 0;
  int   last_eop_edge = -10;
  int   budget = 0;
  bit   budget_ready = 0;
  int   frames_seen = 0;
  llr_t frames [NFR][cDEG_MAX][PLANES];
  int   frame_deg [NFR];

  // expected msg queue is beat-major then lane
  llr_t exp_msg [$];
  int   exp_deg [$];
  logic exp_pf [$];
  int   exp_edge [$];

  cnode_unit #(
    .pLANES    (PLANES),
    .pUSE_NORM (1)
  ) cnode_unit_i (
    .iclk     (iclk),
    .ireset   (ireset),
    .ival     (ival),
    .isop     (isop),
    .ieop     (ieop),
    .ivnode   (ivnode),
    .oval     (oval),
    .osop     (osop),
    .oeop     (oeop),
    .ocnode   (ocnode),
    .odecfail (odecfail),
    .obusy    (obusy)
  );

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  always @(posedge iclk) edge_cnt <= edge_cnt + 1;

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------

  task automatic idle_cycle();
    @(posedge iclk);
    ival <= 1'b0;
    isop <= 1'b0;
    ieop <= 1'b0;
  endtask

  task automatic push_expected(input int f);
    llr_t row [cDEG_MAX];
    llr_t msg [PLANES][cDEG_MAX];
    logic pf;
    logic pf_any;
    pf_any = 1'b0;
    for (int l = 0; l < PLANES; l++) begin
      for (int p = 0; p < cDEG_MAX; p++) row[p] = frames[f][p][l];
      ref_cnode(row, frame_deg[f], 1'b1, msg[l], pf);
      pf_any = pf_any | pf;
    end
    for (int p = 0; p < frame_deg[f]; p++) begin
      for (int l = 0; l < PLANES; l++) exp_msg.push_back(msg[l][p]);
    end
    exp_deg.push_back(frame_deg[f]);
    exp_pf.push_back(pf_any);
  endtask

  task automatic send_frame(input int f, input bit gaps);
    int deg;
    deg = frame_deg[f];
    for (int p = 0; p < deg; p++) begin
      if (gaps && ($random(seed) % 4 == 0)) idle_cycle();
      // bank must be free and the last eop out of the pipe
      if (p == deg - 1) begin
        while (obusy || (edge_cnt < last_eop_edge + 3)) idle_cycle();
      end
      @(posedge iclk);
      ival <= 1'b1;
      isop <= (p == 0);
      ieop <= (p == deg - 1);
      for (int l = 0; l < PLANES; l++) ivnode[l] <= frames[f][p][l];
      if (p == deg - 1) begin
        last_eop_edge = edge_cnt;
        exp_edge.push_back(edge_cnt);
        push_expected(f);
      end
    end
  endtask

  // ----------------------------------------
  // frame contents
  // ----------------------------------------

  task automatic build_frames();
    int sat_row [5];
    sat_row = '{-16, 0, -3, -16, 9};
    frame_deg[0] = 8;                        // distinct magnitudes
    frame_deg[1] = 6;                        // random signs
    frame_deg[2] = 5;                        // saturation and zero
    frame_deg[3] = 1;
    frame_deg[4] = cDEG_MAX;
    for (int f = 0; f < NFR; f++) begin
      if (f >= NDIR) frame_deg[f] = 2 + (($random(seed) & 32'h7fff_ffff) % 31);
      for (int p = 0; p < cDEG_MAX; p++) begin
        for (int l = 0; l < PLANES; l++) begin
          if (f == 0) frames[f][p][l] = llr_t'(15 - p - l);
          else if (f == 2 && p < 5) begin
            if (l == 1) frames[f][p][l] = llr_t'(-16);   // all saturated
            else if (l == 2) frames[f][p][l] = '0;       // all zero
            else frames[f][p][l] = llr_t'(sat_row[p]);
          end
          else frames[f][p][l] = llr_t'($random(seed));
        end
      end
    end
    budget = 40;
    for (int f = 0; f < NFR; f++) budget += 2 * frame_deg[f] + 50;
    budget_ready = 1'b1;
  endtask

  // ----------------------------------------
  // output checker sampling on the falling edge
  // ----------------------------------------

  bit in_frame = 0;
  int bcnt     = 0;
  int cur_deg  = 0;
  logic cur_pf = 0;
  bit after_eop = 0;

  always @(negedge iclk) begin
    if (!ireset) begin
      if (after_eop) begin
        check_bit("obusy after oeop", 1'b0, obusy);
        after_eop = 0;
      end
      if (oval) begin
        check_bit("obusy", 1'b1, obusy);
        if (osop && !in_frame) begin
          if (exp_deg.size() == 0) begin
            report_error("output frame with no expected frame");
          end
          else begin
            cur_deg  = exp_deg.pop_front();
            cur_pf   = exp_pf.pop_front();
            // ieop driven on one edge and osop seen four edges later
            check_count("osop cycle", exp_edge.pop_front() + 5, edge_cnt);
            in_frame = 1;
            bcnt     = 0;
          end
        end
        if (in_frame) begin
          check_bit("osop", bcnt == 0, osop);        // restart inside a frame lands here
          check_bit("oeop", bcnt == cur_deg - 1, oeop);
          check_bit("odecfail", (bcnt == cur_deg - 1) ? cur_pf : 1'b0, odecfail);
          for (int l = 0; l < PLANES; l++) begin
            check_llr($sformatf("ocnode[%0d]", l), exp_msg.pop_front(), ocnode[l]);
          end
          bcnt++;
          if (bcnt == cur_deg) begin
            in_frame  = 0;
            after_eop = 1;
            frames_seen++;
          end
        end
        else if (!osop) report_error("oval high outside an output frame");
      end
      else if (in_frame) begin
        report_error("oval dropped before the end of the frame");
        in_frame = 0;
      end
    end
  end

  // watchdog with a budget that follows the frame degrees
  initial begin
    wait (budget_ready);
    repeat (budget) @(posedge iclk);
    $display("Error: timeout, output frames did not complete in time");
    $display("FAIL: see errors above");
    $finish;
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    ireset = 1'b1;
    ival   = 1'b0;
    isop   = 1'b0;
    ieop   = 1'b0;
    for (int l = 0; l < PLANES; l++) ivnode[l] = '0;
    build_frames();
    repeat (16) @(posedge iclk);
    ireset <= 1'b0;
    @(negedge iclk);
    check_bit("oval after reset", 1'b0, oval);
    check_bit("osop after reset", 1'b0, osop);
    check_bit("oeop after reset", 1'b0, oeop);
    check_bit("odecfail after reset", 1'b0, odecfail);
    check_bit("obusy after reset", 1'b0, obusy);
    for (int f = 0; f < NFR; f++) begin
      send_frame(f, f >= NDIR);
    end
    idle_cycle();
    while (exp_deg.size() != 0 || in_frame) @(posedge iclk);
    repeat (5) @(posedge iclk);
    if (frames_seen != NFR) report_error("number of output frames differs from input");
    $display("errors: %0d mismatch, %0d other, %0d of %0d frames checked",
             mismatch_cnt, other_cnt, frames_seen, NFR);
    if (mismatch_cnt + other_cnt == 0) begin
      $display("PASS: all tests");
    end
    else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
cnode_pkg.sv
lane_in_if.sv
lane_out_if.sv
vnode_dispatch.sv
min_search_lane.sv
cnode_collect.sv
cnode_unit.sv
tb_cnode_unit.sv
